//--- all.f
riscv_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
forwarding_unit.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

//--- cpu_cases.txt
# P <instruction word, hex> loaded from word 0 upward, then the assembly.
# W <rd, decimal> <expected data, hex> in writeback order.
P 00c00093  addi x1, x0, 12
P 00a00113  addi x2, x0, 10
P ffd00193  addi x3, x0, -3
P 00208233  add  x4, x1, x2
P 403082b3  sub  x5, x1, x3
P 0020f333  and  x6, x1, x2
P 0030e3b3  or   x7, x1, x3
P 00120413  addi x8, x4, 1
P 008404b3  add  x9, x8, x8
P 40848533  sub  x10, x9, x8
P 00a02423  sw   x10, 8(x0)
P 00802583  lw   x11, 8(x0)
P 00158633  add  x12, x11, x1
P 00208463  beq  x1, x2, +8    not taken
P 00500693  addi x13, x0, 5
P 00528463  beq  x5, x5, +8    taken
P 06300713  addi x14, x0, 99   skipped
P 00708013  addi x0, x1, 7     x0 write, not traced
P 00168793  addi x15, x13, 1
P 00000063  beq  x0, x0, 0     final loop
W 1  0000000c
W 2  0000000a
W 3  fffffffd
W 4  00000016
W 5  0000000f
W 6  00000008
W 7  fffffffd
W 8  00000017
W 9  0000002e
W 10 00000017
W 11 00000017
W 12 00000023
W 13 00000005
W 15 00000006

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import riscv_pkg::*;
#(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  wire       clk_i,
    input  wire       reset_i,
    input  wire       start_i,
    input  wire       imem_we_i,
    input  word_t     imem_addr_i,
    input  word_t     imem_wdata_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    word_t      if_instr, if_pc, branch_target;
    logic       pc_write, ifid_hold, branch_taken;
    logic       id_ex_reg_write, id_ex_mem_to_reg, id_ex_mem_read, id_ex_mem_write;
    logic       id_ex_alu_src, id_ex_funct7b5;
    alu_op_e    id_ex_alu_op;
    word_t      id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
    logic [2:0] id_ex_funct3;
    reg_addr_t  id_ex_rs1, id_ex_rs2, id_ex_rd;
    fwd_sel_e   fwd_a, fwd_b;
    logic       ex_mem_reg_write, ex_mem_mem_to_reg, ex_mem_read, ex_mem_write;
    word_t      ex_mem_alu_result, ex_mem_store_data;
    reg_addr_t  ex_mem_rd;
    logic       mem_wb_reg_write, mem_wb_mem_to_reg;
    word_t      mem_wb_alu_result, mem_wb_read_data, wb_data;
    reg_addr_t  mem_wb_rd;

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .start_i         (start_i),
        .imem_we_i       (imem_we_i),
        .imem_addr_i     (imem_addr_i),
        .imem_wdata_i    (imem_wdata_i),
        .pc_write_i      (pc_write),
        .hold_i          (ifid_hold),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .instr_o         (if_instr),
        .pc_o            (if_pc)
    );

    decode_stage u_decode (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .instr_i         (if_instr),
        .pc_i            (if_pc),
        .ex_mem_read_i   (id_ex_mem_read), // Load now in EX.
        .wb_rd_i         (mem_wb_rd),
        .wb_data_i       (wb_data),
        .wb_we_i         (mem_wb_reg_write),
        .pc_write_o      (pc_write),
        .hold_o          (ifid_hold),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_reg_write_o  (id_ex_reg_write),
        .ex_mem_to_reg_o (id_ex_mem_to_reg),
        .ex_mem_read_o   (id_ex_mem_read),
        .ex_mem_write_o  (id_ex_mem_write),
        .ex_alu_src_o    (id_ex_alu_src),
        .ex_alu_op_o     (id_ex_alu_op),
        .ex_rs1_data_o   (id_ex_rs1_data),
        .ex_rs2_data_o   (id_ex_rs2_data),
        .ex_imm_o        (id_ex_imm),
        .ex_funct3_o     (id_ex_funct3),
        .ex_funct7b5_o   (id_ex_funct7b5),
        .ex_rs1_o        (id_ex_rs1),
        .ex_rs2_o        (id_ex_rs2),
        .ex_rd_o         (id_ex_rd)
    );

    forwarding_unit u_fwd (
        .ex_rs1_i        (id_ex_rs1),
        .ex_rs2_i        (id_ex_rs2),
        .mem_rd_i        (ex_mem_rd),
        .wb_rd_i         (mem_wb_rd),
        .mem_reg_write_i (ex_mem_reg_write),
        .wb_reg_write_i  (mem_wb_reg_write),
        .fwd_a_o         (fwd_a),
        .fwd_b_o         (fwd_b)
    );

    execute_stage u_execute (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .reg_write_i      (id_ex_reg_write),
        .mem_to_reg_i     (id_ex_mem_to_reg),
        .mem_read_i       (id_ex_mem_read),
        .mem_write_i      (id_ex_mem_write),
        .alu_src_i        (id_ex_alu_src),
        .alu_op_i         (id_ex_alu_op),
        .rs1_data_i       (id_ex_rs1_data),
        .rs2_data_i       (id_ex_rs2_data),
        .imm_i            (id_ex_imm),
        .funct3_i         (id_ex_funct3),
        .funct7b5_i       (id_ex_funct7b5),
        .rd_i             (id_ex_rd),
        .fwd_a_i          (fwd_a),
        .fwd_b_i          (fwd_b),
        .wb_data_i        (wb_data),
        .mem_reg_write_o  (ex_mem_reg_write),
        .mem_mem_to_reg_o (ex_mem_mem_to_reg),
        .mem_read_o       (ex_mem_read),
        .mem_write_o      (ex_mem_write),
        .mem_alu_result_o (ex_mem_alu_result),
        .mem_store_data_o (ex_mem_store_data),
        .mem_rd_o         (ex_mem_rd)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .reg_write_i     (ex_mem_reg_write),
        .mem_to_reg_i    (ex_mem_mem_to_reg),
        .mem_read_i      (ex_mem_read),
        .mem_write_i     (ex_mem_write),
        .alu_result_i    (ex_mem_alu_result),
        .store_data_i    (ex_mem_store_data),
        .rd_i            (ex_mem_rd),
        .wb_reg_write_o  (mem_wb_reg_write),
        .wb_mem_to_reg_o (mem_wb_mem_to_reg),
        .wb_alu_result_o (mem_wb_alu_result),
        .wb_read_data_o  (mem_wb_read_data),
        .wb_rd_o         (mem_wb_rd)
    );

    ////////////////////
    // Writeback
    ////////////////////
    assign wb_data    = mem_wb_mem_to_reg ? mem_wb_read_data : mem_wb_alu_result;
    assign wb_valid_o = mem_wb_reg_write && mem_wb_rd != '0; // x0 writes are dropped.
    assign wb_rd_o    = mem_wb_rd;
    assign wb_data_o  = wb_data;

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import riscv_pkg::*;
(
    input  wire        clk_i,
    input  wire        reset_i,
    input  word_t      instr_i,
    input  word_t      pc_i,
    input  wire        ex_mem_read_i,
    input  reg_addr_t  wb_rd_i,
    input  word_t      wb_data_i,
    input  wire        wb_we_i,
    output logic       pc_write_o,
    output logic       hold_o,
    output logic       branch_taken_o,
    output word_t      branch_target_o,
    output logic       ex_reg_write_o,
    output logic       ex_mem_to_reg_o,
    output logic       ex_mem_read_o,
    output logic       ex_mem_write_o,
    output logic       ex_alu_src_o,
    output alu_op_e    ex_alu_op_o,
    output word_t      ex_rs1_data_o,
    output word_t      ex_rs2_data_o,
    output word_t      ex_imm_o,
    output logic [2:0] ex_funct3_o,
    output logic       ex_funct7b5_o,
    output reg_addr_t  ex_rs1_o,
    output reg_addr_t  ex_rs2_o,
    output reg_addr_t  ex_rd_o
);

    opcode_t   opcode;
    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data, imm;
    logic      reg_write, mem_to_reg, mem_read, mem_write, alu_src, branch;
    alu_op_e   alu_op;
    logic      stall;

    assign opcode = instr_i[6:0];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    register_file u_regs (
        .clk_i      (clk_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (wb_rd_i),
        .rd_data_i  (wb_data_i),
        .we_i       (wb_we_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    ////////////////////
    // Main control
    ////////////////////
    always_comb begin
        {reg_write, mem_to_reg, mem_read, mem_write, alu_src, branch} = '0;
        alu_op = ALUOP_ADD;
        imm    = {{20{instr_i[31]}}, instr_i[31:20]}; // I format.
        case (opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                alu_op    = ALUOP_RTYPE;
            end
            OP_ITYPE: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = ALUOP_ITYPE;
            end
            OP_LOAD: {reg_write, mem_to_reg, mem_read, alu_src} = 4'b1111;
            OP_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OP_BRANCH: begin
                branch = 1'b1;
                alu_op = ALUOP_SUB;
                // Offset in halfwords.
                imm = {{20{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8]};
            end
            default: ;
        endcase
    end

    // Load in EX feeding this instruction.
    assign stall = ex_mem_read_i && ex_rd_o != '0 && (ex_rd_o == rs1 || ex_rd_o == rs2);

    assign pc_write_o      = !stall;
    assign hold_o          = stall;
    assign branch_taken_o  = branch && (rs1_data == rs2_data);
    assign branch_target_o = pc_i + {imm[30:0], 1'b0};

    ////////////////////
    // ID/EX register
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i || stall) begin
            {ex_reg_write_o, ex_mem_to_reg_o, ex_mem_read_o, ex_mem_write_o} <= '0;
            ex_alu_src_o <= 1'b0;
            ex_alu_op_o  <= ALUOP_ADD; // Bubble.
        end else begin
            {ex_reg_write_o, ex_mem_to_reg_o} <= {reg_write, mem_to_reg};
            {ex_mem_read_o, ex_mem_write_o}   <= {mem_read, mem_write};
            ex_alu_src_o <= alu_src;
            ex_alu_op_o  <= alu_op;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_rs1_data_o <= rs1_data;
        ex_rs2_data_o <= rs2_data;
        ex_imm_o      <= imm;
        ex_funct3_o   <= instr_i[14:12];
        ex_funct7b5_o <= instr_i[30];
        ex_rs1_o      <= rs1;
        ex_rs2_o      <= rs2;
        ex_rd_o       <= instr_i[11:7];
    end

    // Branch operands must be settled before decode.
    a_no_branch_in_stall: assert property (
        @(posedge clk_i) disable iff (reset_i) !(branch_taken_o && stall));

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import riscv_pkg::*;
(
    input  wire        clk_i,
    input  wire        reset_i,
    input  wire        reg_write_i,
    input  wire        mem_to_reg_i,
    input  wire        mem_read_i,
    input  wire        mem_write_i,
    input  wire        alu_src_i,
    input  alu_op_e    alu_op_i,
    input  word_t      rs1_data_i,
    input  word_t      rs2_data_i,
    input  word_t      imm_i,
    input  wire  [2:0] funct3_i,
    input  wire        funct7b5_i,
    input  reg_addr_t  rd_i,
    input  fwd_sel_e   fwd_a_i,
    input  fwd_sel_e   fwd_b_i,
    input  word_t      wb_data_i,
    output logic       mem_reg_write_o,
    output logic       mem_mem_to_reg_o,
    output logic       mem_read_o,
    output logic       mem_write_o,
    output word_t      mem_alu_result_o,
    output word_t      mem_store_data_o,
    output reg_addr_t  mem_rd_o
);

    alu_ctrl_e alu_ctrl;
    word_t     op_a, op_b_fwd, op_b, result;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    ////////////////////
    // ALU control
    ////////////////////
    always_comb begin
        alu_ctrl = ALU_ADD; // Loads, stores, addi.
        case (alu_op_i)
            ALUOP_RTYPE: begin
                case (funct3_i)
                    3'b000:  alu_ctrl = funct7b5_i ? ALU_SUB : ALU_ADD;
                    3'b110:  alu_ctrl = ALU_OR;
                    3'b111:  alu_ctrl = ALU_AND;
                    default: alu_ctrl = ALU_ADD;
                endcase
            end
            default: ;
        endcase
    end

    assign op_a     = fwd_mux(fwd_a_i, rs1_data_i, mem_alu_result_o, wb_data_i);
    assign op_b_fwd = fwd_mux(fwd_b_i, rs2_data_i, mem_alu_result_o, wb_data_i);
    assign op_b     = alu_src_i ? imm_i : op_b_fwd;

    always_comb begin
        case (alu_ctrl)
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            default: result = op_a + op_b;
        endcase
    end

    ////////////////////
    // EX/MEM register
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            {mem_reg_write_o, mem_mem_to_reg_o, mem_read_o, mem_write_o} <= '0;
        end else begin
            {mem_reg_write_o, mem_mem_to_reg_o} <= {reg_write_i, mem_to_reg_i};
            {mem_read_o, mem_write_o}           <= {mem_read_i, mem_write_i};
        end
    end

    always_ff @(posedge clk_i) begin
        mem_alu_result_o <= result;
        mem_store_data_o <= op_b_fwd; // Forwarded rs2.
        mem_rd_o         <= rd_i;
    end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import riscv_pkg::*;
#(
    parameter int IMEM_WORDS = 64
) (
    input  wire   clk_i,
    input  wire   reset_i,
    input  wire   start_i,
    input  wire   imem_we_i,
    input  word_t imem_addr_i,
    input  word_t imem_wdata_i,
    input  wire   pc_write_i,
    input  wire   hold_i,
    input  wire   branch_taken_i,
    input  word_t branch_target_i,
    output word_t instr_o,
    output word_t pc_o
);

    localparam int IW = $clog2(IMEM_WORDS);

    logic  started_q;
    word_t pc_q;
    word_t imem [IMEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            started_q <= 1'b0;
            pc_q      <= '0;
        end else begin
            started_q <= started_q | start_i;
            if (started_q && pc_write_i) begin
                pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
            end
        end
    end

    // Program load port.
    always_ff @(posedge clk_i) begin
        if (imem_we_i) imem[imem_addr_i[IW-1:0]] <= imem_wdata_i;
    end

    ////////////////////
    // IF/ID register
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i || !started_q || branch_taken_i) begin
            instr_o <= NOP_INSTR; // Flush slot.
        end else if (!hold_i) begin
            instr_o <= imem[pc_q[IW+1:2]];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) pc_o <= pc_q;
    end

    a_no_load_after_start: assert property (
        @(posedge clk_i) disable iff (reset_i) started_q |-> !imem_we_i);

endmodule

`default_nettype wire

//--- forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit
    import riscv_pkg::*;
(
    input  reg_addr_t ex_rs1_i,
    input  reg_addr_t ex_rs2_i,
    input  reg_addr_t mem_rd_i,
    input  reg_addr_t wb_rd_i,
    input  wire       mem_reg_write_i,
    input  wire       wb_reg_write_i,
    output fwd_sel_e  fwd_a_o,
    output fwd_sel_e  fwd_b_o
);

    // Youngest producer wins.
    function automatic fwd_sel_e select(reg_addr_t rs);
        if (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == rs) return FWD_MEM;
        if (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == rs) return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = select(ex_rs1_i);
        fwd_b_o = select(ex_rs2_i);
    end

endmodule

`default_nettype wire

//--- memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage
    import riscv_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  wire       clk_i,
    input  wire       reset_i,
    input  wire       reg_write_i,
    input  wire       mem_to_reg_i,
    input  wire       mem_read_i,
    input  wire       mem_write_i,
    input  word_t     alu_result_i,
    input  word_t     store_data_i,
    input  reg_addr_t rd_i,
    output logic      wb_reg_write_o,
    output logic      wb_mem_to_reg_o,
    output word_t     wb_alu_result_o,
    output word_t     wb_read_data_o,
    output reg_addr_t wb_rd_o
);

    localparam int DW = $clog2(DMEM_WORDS);

    word_t         dmem [DMEM_WORDS];
    logic [DW-1:0] index;

    assign index = alu_result_i[DW+1:2]; // Word addressed.

    always_ff @(posedge clk_i) begin
        if (mem_write_i) dmem[index] <= store_data_i;
    end

    ////////////////////
    // MEM/WB register
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_reg_write_o  <= 1'b0;
            wb_mem_to_reg_o <= 1'b0;
        end else begin
            wb_reg_write_o  <= reg_write_i;
            wb_mem_to_reg_o <= mem_to_reg_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_alu_result_o <= alu_result_i;
        wb_rd_o         <= rd_i;
        if (mem_read_i) wb_read_data_o <= dmem[index];
    end

    a_read_write_excl: assert property (
        @(posedge clk_i) disable iff (reset_i) !(mem_read_i && mem_write_i));

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
    import riscv_pkg::*;
(
    input  wire       clk_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  word_t     rd_data_i,
    input  wire       we_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs [32];

    always_ff @(posedge clk_i) begin
        if (we_i && rd_i != '0) regs[rd_i] <= rd_data_i;
    end

    // Write-through so decode sees the value retiring this cycle.
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (we_i && rd_i == rs1_i) ? rd_data_i : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (we_i && rd_i == rs2_i) ? rd_data_i : regs[rs2_i];

endmodule

`default_nettype wire

//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // Major opcodes of the kept instructions.
    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_ITYPE  = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // Operation class from decode.
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_RTYPE = 2'b10,
        ALUOP_ITYPE = 2'b11
    } alu_op_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b0001,
        ALU_AND = 4'b0010,
        ALU_OR  = 4'b0011
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run tb_cpu with Verilator, then search the log for failures.
verilator --binary --timing --assert --top-module tb_cpu -f all.f -o sim_tb_cpu > build.log 2>&1 &&
    ./obj_dir/sim_tb_cpu > sim.log 2>&1 &&
    ! grep -q "ERRORS FOUND" sim.log &&
    echo "Simulation passed" || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int IMEM_WORDS    = 64;
    localparam int DMEM_WORDS    = 64;
    localparam int TRACE_TIMEOUT = 100; // Cycles allowed per writeback.
    localparam int IDLE_CYCLES   = 20;
    localparam int QUIET_CYCLES  = 40;

    logic        clk;
    logic        reset;
    logic        start;
    logic        imem_we;
    logic [31:0] imem_addr;
    logic [31:0] imem_wdata;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] prog [$];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_data [$];

    int checks      = 0;
    int errors      = 0;
    int timeouts    = 0;
    int file_errors = 0;

    cpu_top #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .start_i      (start),
        .imem_we_i    (imem_we),
        .imem_addr_i  (imem_addr),
        .imem_wdata_i (imem_wdata),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////
    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        int          rd;
        string       line;
        logic [31:0] value;
        logic [31:0] data;
        fd = $fopen("cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open cpu_cases.txt");
            file_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0) continue;
            case (line.getc(0))
                "P": begin
                    n = $sscanf(line, "P %h", value);
                    if (n == 1) begin
                        prog.push_back(value);
                    end else begin
                        $display("Malformed program line in cpu_cases.txt: %s", line);
                        file_errors++;
                    end
                end
                "W": begin
                    n = $sscanf(line, "W %d %h", rd, data);
                    if (n == 2) begin
                        exp_rd.push_back(rd);
                        exp_data.push_back(data);
                    end else begin
                        $display("Malformed writeback line in cpu_cases.txt: %s", line);
                        file_errors++;
                    end
                end
                default: ; // Comments and blank lines.
            endcase
        end
        $fclose(fd);
        if (prog.size() == 0 || prog.size() > IMEM_WORDS || exp_rd.size() == 0) begin
            $display("cpu_cases.txt has no usable program or expected trace");
            file_errors++;
        end
    endtask

    // One word per cycle through the load port.
    task automatic load_program();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= i;
            imem_wdata <= prog[i];
            @(negedge clk);
            check_equal({31'd0, wb_valid}, 32'd0, "wb_valid_o during program load");
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic expect_idle(input int cycles, input string what);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            check_equal({31'd0, wb_valid}, 32'd0, what);
        end
    endtask

    task automatic wait_writeback(output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < TRACE_TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = wb_valid;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        bit seen;
        int i;
        reset      <= 1'b1;
        start      <= 1'b0;
        imem_we    <= 1'b0;
        imem_addr  <= '0;
        imem_wdata <= '0;
        read_cases();
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        if (file_errors == 0) begin
            load_program();
            expect_idle(IDLE_CYCLES, "wb_valid_o before start");
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;

            for (i = 0; i < exp_rd.size(); i++) begin
                wait_writeback(seen);
                if (!seen) begin
                    $display("Timeout at %0t: writeback %0d to x%0d did not appear",
                             $time, i, exp_rd[i]);
                    timeouts++;
                    break;
                end
                check_equal({27'd0, wb_rd}, exp_rd[i], $sformatf("writeback %0d rd", i));
                check_equal(wb_data, exp_data[i], $sformatf("writeback %0d data", i));
            end
            // Core now spins on its final beq.
            if (timeouts == 0) expect_idle(QUIET_CYCLES, "wb_valid_o in the final loop");
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d, file errors: %0d",
                 checks, errors, timeouts, file_errors);
        if (errors == 0 && timeouts == 0 && file_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
